// ==== source/tinker_isa_pkg.sv ====
package tinker_isa_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int XLEN      = 64;
    localparam int REG_COUNT = 32;
    localparam int LIT_W     = 12;  // literal field

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // ==============================
    // opcodes
    // ==============================
    typedef enum logic [4:0] {
        OP_AND  = 5'b00000,
        OP_OR   = 5'b00001,
        OP_XOR  = 5'b00010,
        OP_NOT  = 5'b00011,
        OP_SHR  = 5'b00100,
        OP_SHRI = 5'b00101,
        OP_SHL  = 5'b00110,
        OP_SHLI = 5'b00111,
        OP_BR   = 5'b01000,  // pc <- rd
        OP_BRR  = 5'b01001,  // pc <- pc + rd
        OP_BRRL = 5'b01010,  // pc <- pc + L
        OP_BRNZ = 5'b01011,
        OP_BRGT = 5'b01110,
        OP_HALT = 5'b01111,
        OP_MOV  = 5'b10001,
        OP_MOVL = 5'b10010,  // low 12 bits of rd only
        OP_ADD  = 5'b11000,
        OP_ADDI = 5'b11001,
        OP_SUB  = 5'b11010,
        OP_SUBI = 5'b11011
    } opcode_e;

    // 32-bit instruction word, opcode in the top bits
    typedef struct packed {
        opcode_e          opcode;
        reg_idx_t         rd;
        reg_idx_t         rs;
        reg_idx_t         rt;
        logic [LIT_W-1:0] lit;
    } instr_t;

endpackage

// ==== source/tinker_pipe_pkg.sv ====
package tinker_pipe_pkg;

    import tinker_isa_pkg::*;

    // ==============================
    // stage records
    // ==============================

    // decode -> execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        opcode_e  opcode;
        reg_idx_t rd;
        logic     use_literal;  // b holds sign-extended L
        word_t    a;            // rs value
        word_t    b;            // rt value or literal
        word_t    rd_val;
        reg_idx_t rs_idx;       // forwarding match
        reg_idx_t rt_idx;
    } issue_t;

    // execute -> result
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     write;
        word_t    value;
        logic     halt;
    } exec_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     write;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

    // register write port, also the forwarding source
    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

// ==== source/tinker_regfile.sv ====
`timescale 1ns/1ps

module tinker_regfile
    import tinker_isa_pkg::*, tinker_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  wb_t      wb,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t rd_idx,
    output word_t    rs_val,
    output word_t    rt_val,
    output word_t    rd_val
);
    word_t regs [REG_COUNT];

    // write-through, same-cycle write wins
    assign rs_val = (wb.en && wb.rd == rs_idx) ? wb.value : regs[rs_idx];
    assign rt_val = (wb.en && wb.rd == rt_idx) ? wb.value : regs[rt_idx];
    assign rd_val = (wb.en && wb.rd == rd_idx) ? wb.value : regs[rd_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

// ==== source/tinker_decode.sv ====
`timescale 1ns/1ps

module tinker_decode
    import tinker_isa_pkg::*, tinker_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000
) (
    input  logic      clk,
    input  logic      reset,
    input  instr_t    fetch_instr,
    input  redirect_t redirect,
    input  word_t     rs_val,
    input  word_t     rt_val,
    input  word_t     rd_val,
    output word_t     fetch_pc,
    output reg_idx_t  rs_idx,
    output reg_idx_t  rt_idx,
    output reg_idx_t  rd_idx,
    output issue_t    issue
);
    word_t  pc;
    word_t  req_pc;      // pc of the fetch in flight
    logic   req_valid;
    logic   ifid_valid;
    word_t  ifid_pc;
    instr_t ifid_instr;
    logic   halt_stop;
    logic   stop;
    logic   use_literal;
    word_t  lit_sext;

    assign fetch_pc = pc;
    assign stop     = halt_stop || (issue.valid && issue.opcode == OP_HALT);

    // ==============================
    // fetch and IF/ID
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= RESET_PC;
            req_pc     <= '0;
            req_valid  <= 1'b0;
            ifid_valid <= 1'b0;
            ifid_pc    <= '0;
            ifid_instr <= '0;
            halt_stop  <= 1'b0;
        end else if (redirect.taken) begin
            pc         <= redirect.target;
            req_valid  <= 1'b0;  // drop in-flight fetch
            ifid_valid <= 1'b0;
            halt_stop  <= 1'b0;
        end else if (stop) begin
            req_valid  <= 1'b0;  // pc frozen
            ifid_valid <= 1'b0;
            halt_stop  <= 1'b1;
        end else begin
            pc         <= pc + 64'd4;
            req_pc     <= pc;
            req_valid  <= 1'b1;
            ifid_valid <= req_valid;
            ifid_pc    <= req_pc;
            ifid_instr <= fetch_instr;
        end
    end

    // ==============================
    // field split and ID/EX
    // ==============================
    assign rd_idx = ifid_instr.rd;
    assign rs_idx = ifid_instr.rs;
    assign rt_idx = ifid_instr.rt;

    assign use_literal = ifid_instr.opcode inside {OP_ADDI, OP_SUBI, OP_SHRI, OP_SHLI,
                                                   OP_MOVL, OP_BRRL};
    assign lit_sext = {{(XLEN-LIT_W){ifid_instr.lit[LIT_W-1]}}, ifid_instr.lit};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue <= '0;
        end else begin
            issue.valid       <= ifid_valid && !redirect.taken && !stop;
            issue.pc          <= ifid_pc;
            issue.opcode      <= ifid_instr.opcode;
            issue.rd          <= ifid_instr.rd;
            issue.use_literal <= use_literal;
            issue.a           <= rs_val;
            issue.b           <= use_literal ? lit_sext : rt_val;
            issue.rd_val      <= rd_val;
            issue.rs_idx      <= ifid_instr.rs;
            issue.rt_idx      <= ifid_instr.rt;
        end
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        fetch_pc[1:0] == 2'b00)
        else $error("fetch_pc misaligned: %h", fetch_pc);

endmodule

// ==== source/tinker_execute.sv ====
`timescale 1ns/1ps

module tinker_execute
    import tinker_isa_pkg::*, tinker_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  issue_t    issue,
    input  wb_t       fwd,
    output exec_t     ex,
    output redirect_t redirect
);
    word_t a;
    word_t b;
    word_t rd_val;
    word_t alu_out;
    word_t target;
    logic  writes;
    logic  taken;

    // ==============================
    // forwarding
    // ==============================
    always_comb begin
        a      = issue.a;
        b      = issue.b;
        rd_val = issue.rd_val;
        if (fwd.en) begin
            if (fwd.rd == issue.rs_idx) a = fwd.value;
            if (fwd.rd == issue.rt_idx && !issue.use_literal) b = fwd.value;
            if (fwd.rd == issue.rd) rd_val = fwd.value;
        end
    end

    // ==============================
    // ALU and branches
    // ==============================
    always_comb begin
        alu_out = '0;
        writes  = 1'b1;
        taken   = 1'b0;
        target  = rd_val;
        case (issue.opcode)
            OP_ADD:  alu_out = a + b;
            OP_ADDI: alu_out = rd_val + b;  // rd is first operand
            OP_SUB:  alu_out = a - b;
            OP_SUBI: alu_out = rd_val - b;
            OP_AND:  alu_out = a & b;
            OP_OR:   alu_out = a | b;
            OP_XOR:  alu_out = a ^ b;
            OP_NOT:  alu_out = ~a;
            OP_SHR, OP_SHRI: alu_out = a >> b[$clog2(XLEN)-1:0];
            OP_SHL, OP_SHLI: alu_out = a << b[$clog2(XLEN)-1:0];
            OP_MOV:  alu_out = a;
            OP_MOVL: alu_out = {rd_val[XLEN-1:LIT_W], b[LIT_W-1:0]};
            OP_BR: begin
                writes = 1'b0;
                taken  = 1'b1;
            end
            OP_BRR: begin
                writes = 1'b0;
                taken  = 1'b1;
                target = issue.pc + rd_val;
            end
            OP_BRRL: begin
                writes = 1'b0;
                taken  = 1'b1;
                target = issue.pc + b;
            end
            OP_BRNZ: begin
                writes = 1'b0;
                taken  = (a != '0);
            end
            OP_BRGT: begin
                writes = 1'b0;
                taken  = ($signed(a) > $signed(b));
            end
            default: writes = 1'b0;  // halt, unknown
        endcase
        redirect.taken  = issue.valid && taken;
        redirect.target = target;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex <= '0;
        end else begin
            ex.valid <= issue.valid;
            ex.pc    <= issue.pc;
            ex.rd    <= issue.rd;
            ex.write <= issue.valid && writes;
            ex.value <= alu_out;
            ex.halt  <= issue.valid && issue.opcode == OP_HALT;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (reset)
        redirect.taken |-> redirect.target[1:0] == 2'b00)
        else $error("branch target misaligned: %h", redirect.target);

endmodule

// ==== source/tinker_result.sv ====
`timescale 1ns/1ps

module tinker_result
    import tinker_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  exec_t   ex,
    output wb_t     wb,
    output retire_t retire,
    output logic    hlt
);
    assign wb = '{en: ex.valid && ex.write, rd: ex.rd, value: ex.value};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire <= '0;
            hlt    <= 1'b0;
        end else begin
            retire.valid <= ex.valid;
            retire.pc    <= ex.pc;
            retire.write <= ex.write;
            retire.rd    <= ex.rd;
            retire.value <= ex.value;
            if (ex.valid && ex.halt) hlt <= 1'b1;  // sticky until reset
        end
    end

    // decode must have stopped issuing behind the halt
    a_quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        $past(hlt) |-> !retire.valid)
        else $error("retire after halt, pc %h", retire.pc);

endmodule

// ==== source/tinker_core.sv ====
`timescale 1ns/1ps

module tinker_core
    import tinker_isa_pkg::*, tinker_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000
) (
    input  logic    clk,
    input  logic    reset,
    output word_t   fetch_pc,
    input  instr_t  fetch_instr,
    output retire_t retire,
    output logic    hlt
);
    issue_t    issue;
    exec_t     ex;
    redirect_t redirect;
    wb_t       wb;
    reg_idx_t  rs_idx;
    reg_idx_t  rt_idx;
    reg_idx_t  rd_idx;
    word_t     rs_val;
    word_t     rt_val;
    word_t     rd_val;

    tinker_decode #(
        .RESET_PC(RESET_PC)
    ) u_decode (
        .clk        (clk),
        .reset      (reset),
        .fetch_instr(fetch_instr),
        .redirect   (redirect),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rd_val     (rd_val),
        .fetch_pc   (fetch_pc),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rd_idx     (rd_idx),
        .issue      (issue)
    );

    tinker_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .wb    (wb),
        .rs_idx(rs_idx),
        .rt_idx(rt_idx),
        .rd_idx(rd_idx),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .rd_val(rd_val)
    );

    tinker_execute u_execute (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .fwd     (wb),      // one-level forwarding
        .ex      (ex),
        .redirect(redirect)
    );

    tinker_result u_result (
        .clk   (clk),
        .reset (reset),
        .ex    (ex),
        .wb    (wb),
        .retire(retire),
        .hlt   (hlt)
    );

endmodule

// ==== tb/tinker_programs.svh ====
`ifndef TINKER_PROGRAMS_SVH
`define TINKER_PROGRAMS_SVH

// each row holds the last-row flag, opcode, rd, rs, rt and literal L
// programs are loaded one after another at RESET_PC
typedef struct packed {
    logic        last;
    opcode_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [11:0] lit;
} prog_row_t;

localparam int NUM_PROGS = 4;
localparam int PROG_ROWS = 52;

localparam prog_row_t PROG_TABLE [PROG_ROWS] = '{
    // ==============================
    // alu, literal and move ops
    // ==============================
    '{1'b0, OP_ADDI, 5'd1,  5'd0, 5'd0, 12'h005},
    '{1'b0, OP_ADDI, 5'd2,  5'd0, 5'd0, 12'hffd},  // -3
    '{1'b0, OP_ADD,  5'd3,  5'd1, 5'd2, 12'h000},
    '{1'b0, OP_SUB,  5'd4,  5'd1, 5'd2, 12'h000},
    '{1'b0, OP_SUBI, 5'd4,  5'd0, 5'd0, 12'h001},
    '{1'b0, OP_AND,  5'd5,  5'd1, 5'd4, 12'h000},
    '{1'b0, OP_OR,   5'd6,  5'd1, 5'd2, 12'h000},
    '{1'b0, OP_XOR,  5'd7,  5'd1, 5'd2, 12'h000},
    '{1'b0, OP_NOT,  5'd8,  5'd1, 5'd0, 12'h000},
    '{1'b0, OP_SHLI, 5'd9,  5'd1, 5'd0, 12'd4},
    '{1'b0, OP_SHRI, 5'd10, 5'd2, 5'd0, 12'd60},
    '{1'b0, OP_SHL,  5'd11, 5'd1, 5'd1, 12'h000},
    '{1'b0, OP_SHR,  5'd12, 5'd2, 5'd1, 12'h000},
    '{1'b0, OP_MOV,  5'd13, 5'd2, 5'd0, 12'h000},
    '{1'b0, OP_MOVL, 5'd13, 5'd0, 5'd0, 12'habc},  // upper bits stay all ones
    '{1'b1, OP_HALT, 5'd0,  5'd0, 5'd0, 12'h000},
    // ==============================
    // back-to-back dependences
    // ==============================
    '{1'b0, OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h003},
    '{1'b0, OP_ADD,  5'd2, 5'd1, 5'd1, 12'h000},
    '{1'b0, OP_ADD,  5'd3, 5'd2, 5'd1, 12'h000},
    '{1'b0, OP_SUB,  5'd4, 5'd3, 5'd2, 12'h000},
    '{1'b0, OP_XOR,  5'd1, 5'd4, 5'd3, 12'h000},
    '{1'b0, opcode_e'(5'h14), 5'd1, 5'd1, 5'd1, 12'hfff},  // unknown opcode retires as no-op
    '{1'b0, OP_MOVL, 5'd1, 5'd0, 5'd0, 12'h123},
    '{1'b0, OP_ADD,  5'd5, 5'd1, 5'd4, 12'h000},
    '{1'b1, OP_HALT, 5'd0, 5'd0, 5'd0, 12'h000},
    // ==============================
    // branches, taken and not taken
    // ==============================
    '{1'b0, OP_BRRL, 5'd0, 5'd0, 5'd0, 12'h008},  // to 0x2008
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h001},
    '{1'b0, OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h001},
    '{1'b0, OP_SHLI, 5'd3, 5'd3, 5'd0, 12'd13},
    '{1'b0, OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h028},  // r3 = 0x2028
    '{1'b0, OP_BRNZ, 5'd3, 5'd0, 5'd0, 12'h000},  // r0 is zero so it falls through
    '{1'b0, OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h001},
    '{1'b0, OP_BRNZ, 5'd3, 5'd1, 5'd0, 12'h000},
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h002},
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h003},
    '{1'b0, OP_BRGT, 5'd3, 5'd0, 5'd1, 12'h000},  // 0 > 1 false
    '{1'b0, OP_SUBI, 5'd2, 5'd0, 5'd0, 12'h001},
    '{1'b0, OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h014},  // r3 = 0x203c
    '{1'b0, OP_BRGT, 5'd3, 5'd1, 5'd2, 12'h000},  // 1 > -1 signed
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h004},
    '{1'b0, OP_ADDI, 5'd5, 5'd0, 5'd0, 12'h008},
    '{1'b0, OP_BRR,  5'd5, 5'd0, 5'd0, 12'h000},
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h005},
    '{1'b0, OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h018},  // r3 = 0x2054
    '{1'b0, OP_BR,   5'd3, 5'd0, 5'd0, 12'h000},
    '{1'b0, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h006},
    '{1'b0, OP_HALT, 5'd0, 5'd0, 5'd0, 12'h000},
    '{1'b1, OP_ADDI, 5'd9, 5'd0, 5'd0, 12'h007},
    // ==============================
    // halt with work right behind it
    // ==============================
    '{1'b0, OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h001},
    '{1'b0, OP_HALT, 5'd0, 5'd0, 5'd0, 12'h000},
    '{1'b0, OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h002},
    '{1'b1, OP_ADDI, 5'd2, 5'd0, 5'd0, 12'h003}
};

`endif

// ==== tb/tb_tinker_core.sv ====
`timescale 1ns/1ps

module tb_tinker_core
    import tinker_isa_pkg::*, tinker_pipe_pkg::*;
;
    localparam word_t       RESET_PC   = 64'h2000;
    localparam int          IMEM_WORDS = 256;
    localparam int          RAND_LEN   = 24;
    localparam int          MAX_STEPS  = 200;
    localparam logic [31:0] SEED       = 32'h7d41_cc7a;

    `include "tinker_programs.svh"

    localparam int WATCHDOG_CYCLES = (PROG_ROWS + RAND_LEN + 1) * 8 + 100;

    localparam opcode_e ALU_OPS [14] = '{OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_AND, OP_OR,
        OP_XOR, OP_NOT, OP_SHR, OP_SHRI, OP_SHL, OP_SHLI, OP_MOV, OP_MOVL};

    logic        clk;
    logic        reset;
    instr_t      fetch_instr;
    word_t       fetch_pc;
    retire_t     retire;
    logic        hlt;

    instr_t      imem [IMEM_WORDS];
    retire_t     exp_q [$];
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rng;
    string       prog_names [NUM_PROGS] = '{"alu", "depend", "branch", "halt"};

    tinker_core #(
        .RESET_PC(RESET_PC)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .fetch_instr(fetch_instr),
        .retire     (retire),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t sext12(input logic [11:0] l);
        return {{52{l[11]}}, l};
    endfunction

    // halt word tagged with its folded index
    function automatic instr_t fill_word(input word_t idx);
        return instr_t'({OP_HALT, idx[26:0] ^ idx[53:27] ^ 27'(idx[63:54])});
    endfunction

    function automatic instr_t fetch_word(input word_t pc);
        word_t idx;
        idx = (pc - RESET_PC) >> 2;
        if (idx < 64'(IMEM_WORDS)) return imem[idx[7:0]];
        return fill_word(idx);
    endfunction

    // instruction port answers one cycle after the request
    always @(posedge clk) begin
        fetch_instr <= fetch_word(fetch_pc);
    end

    function automatic int load_program(input int first);
        int row;
        int i;
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem[k] = fill_word(word_t'(k));
        end
        row = first;
        i = 0;
        do begin
            imem[i] = '{opcode: PROG_TABLE[row].op, rd: PROG_TABLE[row].rd,
                        rs: PROG_TABLE[row].rs, rt: PROG_TABLE[row].rt,
                        lit: PROG_TABLE[row].lit};
            row++;
            i++;
        end while (!PROG_TABLE[row-1].last);
        return row;
    endfunction

    task automatic build_random();
        int k;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = fill_word(word_t'(i));
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            rng = xorshift32(rng);
            k = int'(rng % 32'd14);
            imem[i] = '{opcode: ALU_OPS[k], rd: {2'b00, rng[7:5]}, rs: {2'b00, rng[10:8]},
                        rt: {2'b00, rng[13:11]}, lit: rng[31:20]};  // r0..r7 only
        end
        imem[RAND_LEN] = '{opcode: OP_HALT, rd: 5'd0, rs: 5'd0, rt: 5'd0, lit: 12'h000};
    endtask

    // ==============================
    // reference model
    // ==============================
    task automatic build_expected();
        word_t   regs [REG_COUNT];
        word_t   pc;
        word_t   a;
        word_t   b;
        word_t   rdv;
        word_t   next_pc;
        word_t   value;
        logic    write;
        instr_t  ins;
        retire_t rec;
        exp_q.delete();
        for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] = '0;
        end
        pc = RESET_PC;
        for (int step = 0; step < MAX_STEPS; step++) begin
            ins     = fetch_word(pc);
            a       = regs[ins.rs];
            b       = regs[ins.rt];
            rdv     = regs[ins.rd];
            next_pc = pc + 64'd4;
            value   = '0;
            write   = 1'b1;
            case (ins.opcode)
                OP_ADD:  value = a + b;
                OP_ADDI: value = rdv + sext12(ins.lit);
                OP_SUB:  value = a - b;
                OP_SUBI: value = rdv - sext12(ins.lit);
                OP_AND:  value = a & b;
                OP_OR:   value = a | b;
                OP_XOR:  value = a ^ b;
                OP_NOT:  value = ~a;
                OP_SHR:  value = a >> b[5:0];
                OP_SHRI: value = a >> ins.lit[5:0];
                OP_SHL:  value = a << b[5:0];
                OP_SHLI: value = a << ins.lit[5:0];
                OP_MOV:  value = a;
                OP_MOVL: value = {rdv[63:12], ins.lit};
                OP_BR: begin
                    write   = 1'b0;
                    next_pc = rdv;
                end
                OP_BRR: begin
                    write   = 1'b0;
                    next_pc = pc + rdv;
                end
                OP_BRRL: begin
                    write   = 1'b0;
                    next_pc = pc + sext12(ins.lit);
                end
                OP_BRNZ: begin
                    write = 1'b0;
                    if (a != '0) next_pc = rdv;
                end
                OP_BRGT: begin
                    write = 1'b0;
                    if ($signed(a) > $signed(b)) next_pc = rdv;
                end
                default: write = 1'b0;  // halt, unknown
            endcase
            rec = '{valid: 1'b1, pc: pc, write: write, rd: ins.rd, value: value};
            exp_q.push_back(rec);
            if (write) regs[ins.rd] = value;
            if (ins.opcode == OP_HALT) break;
            pc = next_pc;
        end
    endtask

    // ==============================
    // checks
    // ==============================
    task automatic report_value(input string test, input string sig,
                                input word_t exp, input word_t got);
        $display("FAIL t=%0t %s %s expected %h got %h", $time, test, sig, exp, got);
        errors++;
    endtask

    task automatic report_error(input string test, input string what);
        $display("ERROR t=%0t %s: %s", $time, test, what);
        errors++;
    endtask

    task automatic check_retire(input string test, input retire_t exp);
        if (retire.pc !== exp.pc) report_value(test, "retire.pc", exp.pc, retire.pc);
        if (retire.write !== exp.write) begin
            report_value(test, "retire.write", word_t'(exp.write), word_t'(retire.write));
        end
        if (exp.write) begin
            if (retire.rd !== exp.rd) report_value(test, "retire.rd", word_t'(exp.rd),
                                                   word_t'(retire.rd));
            if (retire.value !== exp.value) report_value(test, "retire.value", exp.value,
                                                         retire.value);
        end
    endtask

    task automatic apply_reset(input string test);
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            if (retire.valid !== 1'b0) report_error(test, "retire.valid set in reset");
            if (hlt !== 1'b0) report_error(test, "hlt set in reset");
            if (fetch_pc !== RESET_PC) report_value(test, "fetch_pc", RESET_PC, fetch_pc);
        end
        reset <= 1'b0;
        @(posedge clk);
        if (fetch_pc !== RESET_PC) report_value(test, "fetch_pc", RESET_PC, fetch_pc);
        if (retire.valid !== 1'b0 || hlt !== 1'b0) report_error(test, "outputs busy after reset");
    endtask

    task automatic run_program(input string test);
        int   start_err;
        int   idx;
        int   cycles;
        int   limit;
        logic done;
        logic exp_hlt;
        start_err = errors;
        build_expected();
        apply_reset(test);
        idx    = 0;
        cycles = 0;
        done   = 1'b0;
        limit  = exp_q.size() * 8 + 50;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
            // hlt goes high together with the halt record, the model's last one
            exp_hlt = retire.valid && idx == exp_q.size() - 1;
            if (hlt !== exp_hlt) report_value(test, "hlt", word_t'(exp_hlt), word_t'(hlt));
            if (retire.valid) begin
                if (idx >= exp_q.size()) report_error(test, "retire beyond the model's halt");
                else check_retire(test, exp_q[idx]);
                idx++;
            end
            if (hlt) done = 1'b1;
        end
        if (!done) report_error(test, "hlt never rose");
        else if (idx != exp_q.size()) report_error(test, "retire count differs from the model");
        repeat (8) begin
            @(posedge clk);
            if (retire.valid) report_error(test, "instruction retired after halt");
            if (!hlt) report_error(test, "hlt dropped before reset");
        end
        if (errors == start_err) begin
            tests_passed++;
            $display("test %-8s ok, %0d records", test, idx);
        end else begin
            tests_failed++;
            $display("test %-8s failed, %0d errors", test, errors - start_err);
        end
    endtask

    // ==============================
    // main sequence and watchdog
    // ==============================
    initial begin
        int row;
        reset        = 1'b1;
        fetch_instr  = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rng          = SEED;
        row          = 0;
        for (int t = 0; t < NUM_PROGS; t++) begin
            row = load_program(row);
            run_program(prog_names[t]);
        end
        build_random();
        run_program("random");
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+tb
source/tinker_isa_pkg.sv
source/tinker_pipe_pkg.sv
source/tinker_regfile.sv
source/tinker_decode.sv
source/tinker_execute.sv
source/tinker_result.sv
source/tinker_core.sv
tb/tb_tinker_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_tinker_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_tinker_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0
